/* list.f */
source/l15Pkg.sv
source/cachePkg.sv
source/missArbiter.sv
source/l15Request.sv
source/l15Response.sv
source/l15Bridge.sv
sim/bridge_properties.sv
sim/bridgeChecker.sv
sim/bridgeTb.sv

/* sim/bridgeChecker.sv */
////////////////////////////////////////////////////////////
// cycle model of the bridge outputs, sampled on rising clk
// grant source is read from the cache reqs two edges back
////////////////////////////////////////////////////////////
`default_nettype none

module bridgeChecker (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               icReq_i,
  input  wire l15Pkg::l15Addr_t   icAddr_i,
  input  wire logic               icAck_i,
  input  wire logic               dcReq_i,
  input  wire cachePkg::dcReq_t   dcReqData_i,
  input  wire logic               dcAck_i,
  input  wire logic               l15Val_i,
  input  wire l15Pkg::l15Req_t    l15Req_i,
  input  wire logic               l15HeaderAck_i,
  input  wire logic               l15RespVal_i,
  input  wire l15Pkg::l15Resp_t   l15Resp_i,
  input  wire logic               l15ReqAck_i,
  input  wire logic               icFillValid_i,
  input  wire cachePkg::icFill_t  icFill_i,
  input  wire logic               dcFillValid_i,
  input  wire cachePkg::dcFill_t  dcFill_i,
  input  wire logic               icInvValid_i,
  input  wire cachePkg::icIndex_t icInvIndex_i,
  input  wire logic               dcInvValid_i,
  input  wire cachePkg::dcIndex_t dcInvIndex_i,
  input  wire logic               storeComplete_i,
  input  wire logic               storeStall_i,
  input  wire logic               coreRun_i,
  output int                      errors_o,
  output int                      checks_o,
  output int                      icTaken_o,
  output int                      dcTaken_o
);
  timeunit 1ns;
  timeprecision 100ps;

  import l15Pkg::*;
  import cachePkg::*;

  // expected values for the current cycle
  logic       eReqAck;
  logic       eIcFv;
  logic       eDcFv;
  logic       eInv;
  logic       eStDone;
  logic       eStall;
  logic       eRun;
  logic       eIcAck;
  logic       eDcAck;
  icFill_t    eIcFill;
  dcFill_t    eDcFill;
  // req history, D2 is the sample the arbiter granted on
  logic       icD1;
  logic       icD2;
  logic       dcD1;
  logic       dcD2;
  logic       valD1;
  logic       takenD1;
  logic       resetD1;
  logic       armed;
  logic       take;
  logic       headerTaken;
  reqSource_t owner;
  l15Req_t    curReq;

  task automatic compareValue(input string name, input logic [319:0] expVal,
                              input logic [319:0] actVal);
    checks_o++;
    if (actVal !== expVal) begin
      errors_o++;
      $display("FAIL %s expected %0h actual %0h", name, expVal, actVal);
    end
  endtask

  task automatic reportProblem(input string msg);
    errors_o++;
    $display("ERROR %s", msg);
  endtask

  // log2 byte count to L1.5 size code
  function automatic l15Size_t storeSizeCode(input logic [2:0] log2Bytes);
    case (log2Bytes)
      3'd0:    return Size1B;
      3'd1:    return Size2B;
      3'd2:    return Size4B;
      default: return Size8B;
    endcase
  endfunction

  function automatic l15Req_t expectedRequest(input reqSource_t src, input l15Addr_t icAddr,
                                              input dcReq_t dc);
    l15Req_t r;
    r = '0;
    if (src == SrcIc) begin
      r.rqtype  = RqImiss;
      r.size    = SizeIline;
      r.address = {icAddr[AddrBits-1:5], 5'b0};
    end else if (dc.isStore) begin
      r.rqtype  = RqStore;
      r.size    = storeSizeCode(dc.stSize);
      r.address = dc.addr;
      r.data    = dc.stData;
    end else begin
      // loads fetch the whole 16-byte line
      r.rqtype  = RqLoad;
      r.size    = SizeDline;
      r.address = {dc.addr[AddrBits-1:4], 4'b0};
    end
    return r;
  endfunction

  initial begin
    errors_o  = 0;
    checks_o  = 0;
    icTaken_o = 0;
    dcTaken_o = 0;
    armed     = 1'b0;
    owner     = SrcNone;
    icD1      = 1'b0;
    icD2      = 1'b0;
    dcD1      = 1'b0;
    dcD2      = 1'b0;
    valD1     = 1'b0;
    takenD1   = 1'b0;
    resetD1   = 1'b0;
  end

  always @(posedge clk) begin
    if (armed) begin
      compareValue("l15ReqAck", eReqAck, l15ReqAck_i);
      compareValue("icFillValid", eIcFv, icFillValid_i);
      compareValue("dcFillValid", eDcFv, dcFillValid_i);
      compareValue("icInvValid", eInv, icInvValid_i);
      compareValue("dcInvValid", eInv, dcInvValid_i);
      compareValue("storeComplete", eStDone, storeComplete_i);
      compareValue("storeStall", eStall, storeStall_i);
      compareValue("coreRun", eRun, coreRun_i);
      compareValue("icAck", eIcAck, icAck_i);
      compareValue("dcAck", eDcAck, dcAck_i);
      if (eIcFv) begin
        compareValue("icFill", eIcFill, icFill_i);
      end
      if (eDcFv) begin
        compareValue("dcFill", eDcFill, dcFill_i);
      end
      if (eInv) begin
        compareValue("icInvIndex", eIcFill.index, icInvIndex_i);
        compareValue("dcInvIndex", eDcFill.index, dcInvIndex_i);
      end
      if (l15Val_i && (takenD1 || resetD1)) begin
        reportProblem("l15 val high right after a header ack or during reset");
      end
      // new request on the port, source fixed by the priority rule
      if (l15Val_i && !valD1) begin
        if (owner != SrcNone) begin
          reportProblem("second l15 request while one is in flight");
        end else if (!icD2 && !dcD2) begin
          reportProblem("l15 val rose without a cache request two cycles before");
        end else begin
          owner  = icD2 ? SrcIc : SrcDc;
          curReq = expectedRequest(owner, icAddr_i, dcReqData_i);
          compareValue("l15Request", curReq, l15Req_i);
        end
      end
    end

    take        = l15RespVal_i && !eReqAck;
    headerTaken = l15Val_i && l15HeaderAck_i && (owner != SrcNone);
    if (headerTaken && owner == SrcIc) begin
      icTaken_o++;
    end
    if (headerTaken && owner == SrcDc) begin
      dcTaken_o++;
    end

    if (!rst_n) begin
      eReqAck = 1'b0;
      eIcFv   = 1'b0;
      eDcFv   = 1'b0;
      eInv    = 1'b0;
      eStDone = 1'b0;
      eStall  = 1'b0;
      eRun    = 1'b0;
      eIcAck  = 1'b0;
      eDcAck  = 1'b0;
      owner   = SrcNone;
    end else begin
      eReqAck = take;
      eIcFv   = take && (l15Resp_i.returntype == RetIfill);
      eDcFv   = take && (l15Resp_i.returntype == RetLoad);
      eInv    = take && (l15Resp_i.returntype == RetEvict);
      eStDone = take && (l15Resp_i.returntype == RetStAck);
      if (headerTaken && curReq.rqtype == RqStore) begin
        eStall = 1'b1;
      end else if (eStDone) begin
        eStall = 1'b0;
      end
      if (take && l15Resp_i.returntype == RetInt) begin
        eRun = 1'b1;
      end
      // tag above index, index above byte offset
      if (take) begin
        eIcFill.tag   = l15Resp_i.address[AddrBits-1:IcIndexBits+IcOffsetBits];
        eIcFill.index = l15Resp_i.address[IcOffsetBits +: IcIndexBits];
        eIcFill.line  = l15Resp_i.data;
        eDcFill.tag   = l15Resp_i.address[AddrBits-1:DcIndexBits+DcOffsetBits];
        eDcFill.index = l15Resp_i.address[DcOffsetBits +: DcIndexBits];
        eDcFill.line  = {l15Resp_i.data[1], l15Resp_i.data[0]};
      end
      // ack up after header, down one cycle after req drops
      if (eIcAck && !icReq_i) begin
        eIcAck = 1'b0;
        owner  = SrcNone;
      end else if (headerTaken && owner == SrcIc) begin
        eIcAck = 1'b1;
      end
      if (eDcAck && !dcReq_i) begin
        eDcAck = 1'b0;
        owner  = SrcNone;
      end else if (headerTaken && owner == SrcDc) begin
        eDcAck = 1'b1;
      end
    end

    takenD1 = headerTaken;
    resetD1 = !rst_n;
    valD1   = l15Val_i;
    icD2    = icD1;
    icD1    = icReq_i;
    dcD2    = dcD1;
    dcD1    = dcReq_i;
    if (!rst_n) begin
      armed = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sim/bridgeTb.sv */
////////////////////////////////////////////////////////////
// random traffic from both caches and an L1.5 model from a fixed seed
// returns are random and not tied to the requests in flight
////////////////////////////////////////////////////////////
`default_nettype none

module bridgeTb;
  timeunit 1ns;
  timeprecision 100ps;

  import l15Pkg::*;
  import cachePkg::*;

  localparam int NumReqs       = 200;
  localparam int TimeoutCycles = NumReqs * 20 + 500;

  logic     clk;
  logic     rst_n;
  logic     icReq;
  l15Addr_t icAddr;
  logic     icAck;
  logic     dcReq;
  dcReq_t   dcData;
  logic     dcAck;
  logic     l15Val;
  l15Req_t  l15Req;
  logic     headerAck;
  logic     respVal;
  l15Resp_t resp;
  logic     reqAck;
  logic     icFillValid;
  icFill_t  icFill;
  logic     dcFillValid;
  dcFill_t  dcFill;
  logic     icInvValid;
  icIndex_t icInvIndex;
  logic     dcInvValid;
  dcIndex_t dcInvIndex;
  logic     storeComplete;
  logic     storeStall;
  logic     coreRun;
  int       chkErrors;
  int       chkChecks;
  int       icTaken;
  int       dcTaken;
  int       tbErrors;
  int       totalErrors;
  int       cycleCount;
  logic     stopReturns;
  logic     returnsDone;

  l15Bridge u_dut (
    .clk(clk), .rst_n(rst_n),
    .icReq_i(icReq), .icAddr_i(icAddr), .icAck_o(icAck),
    .dcReq_i(dcReq), .dcReqData_i(dcData), .dcAck_o(dcAck),
    .l15Val_o(l15Val), .l15Req_o(l15Req), .l15HeaderAck_i(headerAck),
    .l15RespVal_i(respVal), .l15Resp_i(resp), .l15ReqAck_o(reqAck),
    .icFillValid_o(icFillValid), .icFill_o(icFill),
    .dcFillValid_o(dcFillValid), .dcFill_o(dcFill),
    .icInvValid_o(icInvValid), .icInvIndex_o(icInvIndex),
    .dcInvValid_o(dcInvValid), .dcInvIndex_o(dcInvIndex),
    .storeComplete_o(storeComplete), .storeStall_o(storeStall), .coreRun_o(coreRun)
  );

  bridgeChecker u_checker (
    .clk(clk), .rst_n(rst_n),
    .icReq_i(icReq), .icAddr_i(icAddr), .icAck_i(icAck),
    .dcReq_i(dcReq), .dcReqData_i(dcData), .dcAck_i(dcAck),
    .l15Val_i(l15Val), .l15Req_i(l15Req), .l15HeaderAck_i(headerAck),
    .l15RespVal_i(respVal), .l15Resp_i(resp), .l15ReqAck_i(reqAck),
    .icFillValid_i(icFillValid), .icFill_i(icFill),
    .dcFillValid_i(dcFillValid), .dcFill_i(dcFill),
    .icInvValid_i(icInvValid), .icInvIndex_i(icInvIndex),
    .dcInvValid_i(dcInvValid), .dcInvIndex_i(dcInvIndex),
    .storeComplete_i(storeComplete), .storeStall_i(storeStall), .coreRun_i(coreRun),
    .errors_o(chkErrors), .checks_o(chkChecks), .icTaken_o(icTaken), .dcTaken_o(dcTaken)
  );

  bind l15Bridge bridgeProperties u_props (
    .clk(clk), .rst_n(rst_n), .val_i(l15Val_o), .req_i(l15Req_o),
    .headerAck_i(l15HeaderAck_i), .reqAck_i(l15ReqAck_o),
    .icAck_i(icAck_o), .dcAck_i(dcAck_o)
  );

  function automatic logic [63:0] random64();
    logic [63:0] r;
    r[63:32] = $urandom();
    r[31:0]  = $urandom();
    return r;
  endfunction

  // low 40 bits of a random doubleword
  function automatic l15Addr_t randomAddr();
    logic [63:0] r;
    r = random64();
    return r[AddrBits-1:0];
  endfunction

  // all waits land 1 ns after the rising edge
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idleCycles(input int maxCycles);
    repeat ($urandom_range(maxCycles, 0)) begin
      nextCycle();
    end
  endtask

  // four-phase req/ack with payload held until ack
  task automatic runIcache(input int count);
    repeat (count) begin
      idleCycles(3);
      icAddr = randomAddr();
      icReq  = 1'b1;
      do nextCycle(); while (!icAck);
      icReq = 1'b0;
      do nextCycle(); while (icAck);
    end
  endtask

  task automatic runDcache(input int count);
    repeat (count) begin
      idleCycles(3);
      dcData.isStore = 1'($urandom_range(1, 0));
      dcData.addr    = randomAddr();
      dcData.stData  = random64();
      dcData.stSize  = 3'($urandom_range(3, 0));
      dcReq          = 1'b1;
      do nextCycle(); while (!dcAck);
      dcReq = 1'b0;
      do nextCycle(); while (dcAck);
    end
  endtask

  // returns held until the bridge acks them
  task automatic runReturns();
    l15Rettype_t kinds [5];
    kinds = '{RetLoad, RetIfill, RetEvict, RetStAck, RetInt};
    while (!stopReturns) begin
      idleCycles(3);
      resp.returntype = kinds[$urandom_range(4, 0)];
      resp.address    = randomAddr();
      for (int i = 0; i < 4; i++) begin
        resp.data[i] = random64();
      end
      respVal = 1'b1;
      do nextCycle(); while (!reqAck);
      respVal = 1'b0;
    end
    returnsDone = 1'b1;
  endtask

  task automatic checkCount(input string name, input int expVal, input int actVal);
    if (actVal != expVal) begin
      tbErrors++;
      $display("FAIL %s expected %0d actual %0d", name, expVal, actVal);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // header ack 0 to 5 cycles after val is seen
  initial begin
    forever begin
      nextCycle();
      if (l15Val) begin
        idleCycles(5);
        headerAck = 1'b1;
        nextCycle();
        headerAck = 1'b0;
      end
    end
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout, run stopped after %0d cycles", cycleCount);
    $display("tests failed");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    icReq       = 1'b0;
    icAddr      = '0;
    dcReq       = 1'b0;
    dcData      = '0;
    headerAck   = 1'b0;
    respVal     = 1'b0;
    resp        = '0;
    stopReturns = 1'b0;
    returnsDone = 1'b0;
    tbErrors    = 0;
    totalErrors = 0;
    void'($urandom(32'h3844));
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fork
      runReturns();
    join_none
    fork
      runIcache(NumReqs / 2);
      runDcache(NumReqs / 2);
    join
    stopReturns = 1'b1;
    wait (returnsDone);
    // last pulses still have to reach the checker
    repeat (4) @(posedge clk);
    checkCount("icRequestCount", NumReqs / 2, icTaken);
    checkCount("dcRequestCount", NumReqs / 2, dcTaken);
    totalErrors = chkErrors + tbErrors + u_dut.u_props.failCount;
    $display("checks %0d, errors %0d", chkChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/bridge_properties.sv */
////////////////////////////////////////////////////////////
// handshake rules on the L1.5 port and on the cache acks
////////////////////////////////////////////////////////////
`default_nettype none

module bridgeProperties (
  input wire logic            clk,
  input wire logic            rst_n,
  input wire logic            val_i,
  input wire l15Pkg::l15Req_t req_i,
  input wire logic            headerAck_i,
  input wire logic            reqAck_i,
  input wire logic            icAck_i,
  input wire logic            dcAck_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed assertion count
  int failCount = 0;

  // request stays up and unchanged until the header is taken
  valHold: assert property (@(posedge clk) disable iff (!rst_n)
    val_i && !headerAck_i |=> val_i && $stable(req_i))
    else begin
      failCount++;
      $error("l15 val dropped or payload changed before header ack");
    end

  // return ack is a single-cycle pulse
  reqAckPulse: assert property (@(posedge clk) disable iff (!rst_n)
    reqAck_i |=> !reqAck_i)
    else begin
      failCount++;
      $error("l15 return ack held longer than one cycle");
    end

  // one cache owns the port at a time
  acksExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(icAck_i && dcAck_i))
    else begin
      failCount++;
      $error("icache and dcache acks high together");
    end

endmodule

`default_nettype wire

/* source/cachePkg.sv */
////////////////////////////////////////////////////////////
// L1 geometry, direct index split of the 40-bit address
////////////////////////////////////////////////////////////
`default_nettype none

package cachePkg;

  localparam int IcIndexBits  = 7;
  localparam int DcIndexBits  = 8;
  localparam int IcLineBits   = 256;
  localparam int DcLineBits   = 128;
  // byte offset inside a line
  localparam int IcOffsetBits = 5;
  localparam int DcOffsetBits = 4;
  localparam int IcTagBits    = l15Pkg::AddrBits - IcIndexBits - IcOffsetBits;
  localparam int DcTagBits    = l15Pkg::AddrBits - DcIndexBits - DcOffsetBits;

  typedef logic [IcIndexBits-1:0] icIndex_t;
  typedef logic [IcTagBits-1:0]   icTag_t;
  typedef logic [DcIndexBits-1:0] dcIndex_t;
  typedef logic [DcTagBits-1:0]   dcTag_t;
  typedef logic [IcLineBits-1:0]  icLine_t;
  typedef logic [DcLineBits-1:0]  dcLine_t;

  // stSize is log2 of the byte count, 0 to 3
  typedef struct packed {
    logic                isStore;
    l15Pkg::l15Addr_t    addr;
    l15Pkg::doubleword_t stData;
    logic [2:0]          stSize;
  } dcReq_t;

  typedef struct packed {
    icTag_t   tag;
    icIndex_t index;
    icLine_t  line;
  } icFill_t;

  typedef struct packed {
    dcTag_t   tag;
    dcIndex_t index;
    dcLine_t  line;
  } dcFill_t;

  typedef enum logic [1:0] {SrcNone, SrcIc, SrcDc} reqSource_t;

endpackage

`default_nettype wire

/* source/l15Bridge.sv */
////////////////////////////////////////////////////////////
// L1 caches to L1.5 bridge, one outstanding request
////////////////////////////////////////////////////////////
`default_nettype none

module l15Bridge (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // cache request channels
  input  wire logic               icReq_i,
  input  wire l15Pkg::l15Addr_t   icAddr_i,
  output logic                    icAck_o,
  input  wire logic               dcReq_i,
  input  wire cachePkg::dcReq_t   dcReqData_i,
  output logic                    dcAck_o,
  // L1.5 request side
  output logic                    l15Val_o,
  output l15Pkg::l15Req_t         l15Req_o,
  input  wire logic               l15HeaderAck_i,
  // L1.5 return side
  input  wire logic               l15RespVal_i,
  input  wire l15Pkg::l15Resp_t   l15Resp_i,
  output logic                    l15ReqAck_o,
  // fills, invalidations, stores, wakeup
  output logic                    icFillValid_o,
  output cachePkg::icFill_t       icFill_o,
  output logic                    dcFillValid_o,
  output cachePkg::dcFill_t       dcFill_o,
  output logic                    icInvValid_o,
  output cachePkg::icIndex_t      icInvIndex_o,
  output logic                    dcInvValid_o,
  output cachePkg::dcIndex_t      dcInvIndex_o,
  output logic                    storeComplete_o,
  output logic                    storeStall_o,
  output logic                    coreRun_o
);

  import l15Pkg::*;
  import cachePkg::*;

  logic       grantValid;
  reqSource_t grantSrc;
  l15Addr_t   grantIc;
  dcReq_t     grantDc;
  logic       headerTaken;
  logic       storeIssued;

  missArbiter u_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .icReq_i       (icReq_i),
    .icAddr_i      (icAddr_i),
    .dcReq_i       (dcReq_i),
    .dcReqData_i   (dcReqData_i),
    .headerTaken_i (headerTaken),
    .icAck_o       (icAck_o),
    .dcAck_o       (dcAck_o),
    .grantValid_o  (grantValid),
    .grantSrc_o    (grantSrc),
    .grantIc_o     (grantIc),
    .grantDc_o     (grantDc)
  );

  l15Request u_request (
    .clk            (clk),
    .rst_n          (rst_n),
    .grantValid_i   (grantValid),
    .grantSrc_i     (grantSrc),
    .grantIc_i      (grantIc),
    .grantDc_i      (grantDc),
    .l15HeaderAck_i (l15HeaderAck_i),
    .l15Val_o       (l15Val_o),
    .l15Req_o       (l15Req_o),
    .headerTaken_o  (headerTaken),
    .storeIssued_o  (storeIssued)
  );

  l15Response u_response (
    .clk             (clk),
    .rst_n           (rst_n),
    .l15RespVal_i    (l15RespVal_i),
    .l15Resp_i       (l15Resp_i),
    .storeIssued_i   (storeIssued),
    .l15ReqAck_o     (l15ReqAck_o),
    .icFillValid_o   (icFillValid_o),
    .icFill_o        (icFill_o),
    .dcFillValid_o   (dcFillValid_o),
    .dcFill_o        (dcFill_o),
    .icInvValid_o    (icInvValid_o),
    .icInvIndex_o    (icInvIndex_o),
    .dcInvValid_o    (dcInvValid_o),
    .dcInvIndex_o    (dcInvIndex_o),
    .storeComplete_o (storeComplete_o),
    .storeStall_o    (storeStall_o),
    .coreRun_o       (coreRun_o)
  );

endmodule

`default_nettype wire

/* source/l15Pkg.sv */
////////////////////////////////////////////////////////////
// L1.5 port encodings, one request and one return at a time
// no atomics, prefetch, thread id or error fields
////////////////////////////////////////////////////////////
`default_nettype none

package l15Pkg;

  // physical address width on the L1.5 port
  localparam int AddrBits = 40;

  typedef logic [AddrBits-1:0] l15Addr_t;
  typedef logic [4:0]          l15Rqtype_t;
  typedef logic [3:0]          l15Rettype_t;
  typedef logic [2:0]          l15Size_t;
  typedef logic [63:0]         doubleword_t;

  // request types
  localparam l15Rqtype_t RqLoad  = 5'b00000;
  localparam l15Rqtype_t RqImiss = 5'b10000;
  localparam l15Rqtype_t RqStore = 5'b00001;

  // return types
  localparam l15Rettype_t RetLoad  = 4'b0000;
  localparam l15Rettype_t RetIfill = 4'b0001;
  localparam l15Rettype_t RetEvict = 4'b0011;
  localparam l15Rettype_t RetStAck = 4'b0100;
  localparam l15Rettype_t RetInt   = 4'b0111;

  // access sizes
  localparam l15Size_t Size1B    = 3'b000;
  localparam l15Size_t Size2B    = 3'b001;
  localparam l15Size_t Size4B    = 3'b010;
  localparam l15Size_t Size8B    = 3'b011;
  localparam l15Size_t SizeDline = 3'b111;
  localparam l15Size_t SizeIline = 3'b101;

  // request header plus one doubleword of store data
  typedef struct packed {
    l15Rqtype_t  rqtype;
    l15Size_t    size;
    l15Addr_t    address;
    logic        nc;
    doubleword_t data;
  } l15Req_t;

  // data[0] is the lowest doubleword of the line
  typedef struct packed {
    l15Rettype_t       returntype;
    l15Addr_t          address;
    doubleword_t [3:0] data;
  } l15Resp_t;

endpackage

`default_nettype wire

/* source/l15Request.sv */
////////////////////////////////////////////////////////////
// one request in flight, val held until header ack
////////////////////////////////////////////////////////////
`default_nettype none

module l15Request (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 grantValid_i,
  input  wire cachePkg::reqSource_t grantSrc_i,
  input  wire l15Pkg::l15Addr_t     grantIc_i,
  input  wire cachePkg::dcReq_t     grantDc_i,
  input  wire logic                 l15HeaderAck_i,
  output logic                      l15Val_o,
  output l15Pkg::l15Req_t           l15Req_o,
  output logic                      headerTaken_o,
  output logic                      storeIssued_o
);

  import l15Pkg::*;
  import cachePkg::*;

  l15Req_t  nextReq;
  l15Req_t  reqQ;
  l15Size_t storeSize;
  logic     valQ;
  logic     load;

  // cache store size is log2 of bytes
  always_comb begin
    case (grantDc_i.stSize)
      3'd0:    storeSize = Size1B;
      3'd1:    storeSize = Size2B;
      3'd2:    storeSize = Size4B;
      default: storeSize = Size8B;
    endcase
  end

  // request header from the granted source
  always_comb begin
    nextReq    = '0;
    // all traffic is cacheable
    nextReq.nc = 1'b0;
    case (grantSrc_i)
      SrcIc: begin
        nextReq.rqtype  = RqImiss;
        nextReq.size    = SizeIline;
        nextReq.address = {grantIc_i[AddrBits-1:IcOffsetBits], {IcOffsetBits{1'b0}}};
      end
      SrcDc: begin
        if (grantDc_i.isStore) begin
          nextReq.rqtype  = RqStore;
          nextReq.size    = storeSize;
          nextReq.address = grantDc_i.addr;
          nextReq.data    = grantDc_i.stData;
        end else begin
          // line load, address aligned to 16 bytes
          nextReq.rqtype  = RqLoad;
          nextReq.size    = SizeDline;
          nextReq.address = {grantDc_i.addr[AddrBits-1:DcOffsetBits],
                             {DcOffsetBits{1'b0}}};
        end
      end
      default: nextReq = '0;
    endcase
  end

  // new grant only lands while idle
  assign load = grantValid_i && !valQ;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valQ <= 1'b0;
    end else if (load) begin
      valQ <= 1'b1;
    end else if (headerTaken_o) begin
      valQ <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      reqQ <= nextReq;
    end
  end

  assign l15Val_o      = valQ;
  assign l15Req_o      = reqQ;
  // same-cycle so the arbiter acks right after the header goes
  assign headerTaken_o = valQ && l15HeaderAck_i;
  assign storeIssued_o = headerTaken_o && (reqQ.rqtype == RqStore);

endmodule

`default_nettype wire

/* source/l15Response.sv */
////////////////////////////////////////////////////////////
// returns acked one cycle after val, next taken at t+2
////////////////////////////////////////////////////////////
`default_nettype none

module l15Response (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               l15RespVal_i,
  input  wire l15Pkg::l15Resp_t   l15Resp_i,
  input  wire logic               storeIssued_i,
  output logic                    l15ReqAck_o,
  output logic                    icFillValid_o,
  output cachePkg::icFill_t       icFill_o,
  output logic                    dcFillValid_o,
  output cachePkg::dcFill_t       dcFill_o,
  output logic                    icInvValid_o,
  output cachePkg::icIndex_t      icInvIndex_o,
  output logic                    dcInvValid_o,
  output cachePkg::dcIndex_t      dcInvIndex_o,
  output logic                    storeComplete_o,
  output logic                    storeStall_o,
  output logic                    coreRun_o
);

  import l15Pkg::*;
  import cachePkg::*;

  logic        take;
  l15Rettype_t retType;
  icTag_t      retIcTag;
  icIndex_t    retIcIndex;
  dcTag_t      retDcTag;
  dcIndex_t    retDcIndex;

  // val still high during the ack cycle, skip it
  assign take    = l15RespVal_i && !l15ReqAck_o;
  assign retType = l15Resp_i.returntype;

  // tag and index split for each cache
  assign retIcTag   = l15Resp_i.address[AddrBits-1 -: IcTagBits];
  assign retIcIndex = l15Resp_i.address[IcOffsetBits +: IcIndexBits];
  assign retDcTag   = l15Resp_i.address[AddrBits-1 -: DcTagBits];
  assign retDcIndex = l15Resp_i.address[DcOffsetBits +: DcIndexBits];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      l15ReqAck_o     <= 1'b0;
      icFillValid_o   <= 1'b0;
      dcFillValid_o   <= 1'b0;
      icInvValid_o    <= 1'b0;
      dcInvValid_o    <= 1'b0;
      storeComplete_o <= 1'b0;
      storeStall_o    <= 1'b0;
      coreRun_o       <= 1'b0;
    end else begin
      l15ReqAck_o     <= take;
      icFillValid_o   <= take && (retType == RetIfill);
      dcFillValid_o   <= take && (retType == RetLoad);
      // evict hits both caches at once
      icInvValid_o    <= take && (retType == RetEvict);
      dcInvValid_o    <= take && (retType == RetEvict);
      storeComplete_o <= take && (retType == RetStAck);
      // a new store wins over the older store's ack
      if (storeIssued_i) begin
        storeStall_o <= 1'b1;
      end else if (take && (retType == RetStAck)) begin
        storeStall_o <= 1'b0;
      end
      // wakeup latch, only reset clears it
      if (take && (retType == RetInt)) begin
        coreRun_o <= 1'b1;
      end
    end
  end

  // payload registers, qualified by the valid pulses
  always_ff @(posedge clk) begin
    if (take) begin
      icFill_o.tag   <= retIcTag;
      icFill_o.index <= retIcIndex;
      // all four doublewords, data[0] lowest
      icFill_o.line  <= l15Resp_i.data;
      dcFill_o.tag   <= retDcTag;
      dcFill_o.index <= retDcIndex;
      // first two doublewords only
      dcFill_o.line  <= l15Resp_i.data[1:0];
      icInvIndex_o   <= retIcIndex;
      dcInvIndex_o   <= retDcIndex;
    end
  end

endmodule

`default_nettype wire

/* source/missArbiter.sv */
////////////////////////////////////////////////////////////
// four-phase req/ack from both caches, icache wins a tie
////////////////////////////////////////////////////////////
`default_nettype none

module missArbiter (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 icReq_i,
  input  wire l15Pkg::l15Addr_t     icAddr_i,
  input  wire logic                 dcReq_i,
  input  wire cachePkg::dcReq_t     dcReqData_i,
  input  wire logic                 headerTaken_i,
  output logic                      icAck_o,
  output logic                      dcAck_o,
  output logic                      grantValid_o,
  output cachePkg::reqSource_t      grantSrc_o,
  output l15Pkg::l15Addr_t          grantIc_o,
  output cachePkg::dcReq_t          grantDc_o
);

  import cachePkg::*;

  typedef enum logic [1:0] {Idle, Busy, Acking, Release} arbState_t;

  arbState_t state;
  logic      ackQ;
  // req of the channel that owns the grant
  logic      srcReq;

  assign srcReq  = (grantSrc_o == SrcIc) ? icReq_i : dcReq_i;
  assign icAck_o = ackQ && (grantSrc_o == SrcIc);
  assign dcAck_o = ackQ && (grantSrc_o == SrcDc);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= Idle;
      ackQ         <= 1'b0;
      grantValid_o <= 1'b0;
      grantSrc_o   <= SrcNone;
    end else begin
      // grant valid is a single-cycle pulse
      grantValid_o <= 1'b0;
      case (state)
        Idle: begin
          if (icReq_i) begin
            grantSrc_o   <= SrcIc;
            grantValid_o <= 1'b1;
            state        <= Busy;
          end else if (dcReq_i) begin
            grantSrc_o   <= SrcDc;
            grantValid_o <= 1'b1;
            state        <= Busy;
          end
        end
        // waiting for the L1.5 to take the header
        Busy: begin
          if (headerTaken_i) begin
            ackQ  <= 1'b1;
            state <= Acking;
          end
        end
        // ack high until the cache drops req
        Acking: begin
          if (!srcReq) begin
            ackQ  <= 1'b0;
            state <= Release;
          end
        end
        // turnaround so the cache sees ack low before rearbitration
        Release: begin
          grantSrc_o <= SrcNone;
          state      <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

  // payload capture, last idle cycle is the granted one
  always_ff @(posedge clk) begin
    if (state == Idle) begin
      grantIc_o <= icAddr_i;
      grantDc_o <= dcReqData_i;
    end
  end

endmodule

`default_nettype wire
